// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_core
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+100

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	$(OBJ_DIR)/V$(TOP) $(SIM_ARGS)

lint:
	$(VERILATOR) --lint-only --timing --assert -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: alu.sv
`timescale 1ns/1ps

module alu (
    input  core_pkg::ctrl_t           ctrl_i,
    input  logic [core_pkg::XLEN-1:0] rs1_data_i,
    input  logic [core_pkg::XLEN-1:0] rs2_data_i,
    input  logic [core_pkg::XLEN-1:0] pc_i,
    input  logic [core_pkg::XLEN-1:0] imm_i,
    output logic [core_pkg::XLEN-1:0] result_o
);
    import core_pkg::*;

    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [4:0]      shamt;

    always_comb begin
        case (ctrl_i.op1_sel)
            OP1_REG: op_a = rs1_data_i;
            OP1_PC:  op_a = pc_i;
            default: op_a = '0;
        endcase
        op_b  = (ctrl_i.op2_sel == OP2_IMM) ? imm_i : rs2_data_i;
        shamt = op_b[4:0];

        case (ctrl_i.alu_op)
            ALU_ADD:    result_o = op_a + op_b;
            ALU_SUB:    result_o = op_a - op_b;
            ALU_SLL:    result_o = op_a << shamt;
            ALU_SLT:    result_o = {31'b0, $signed(op_a) < $signed(op_b)};
            ALU_SLTU:   result_o = {31'b0, op_a < op_b};
            ALU_XOR:    result_o = op_a ^ op_b;
            ALU_SRL:    result_o = op_a >> shamt;
            ALU_SRA:    result_o = $unsigned($signed(op_a) >>> shamt);
            ALU_OR:     result_o = op_a | op_b;
            ALU_AND:    result_o = op_a & op_b;
            ALU_PASS_B: result_o = op_b;
            default:    result_o = '0;
        endcase
    end

endmodule

// File: branch_unit.sv
`timescale 1ns/1ps

module branch_unit (
    input  core_pkg::ctrl_t           ctrl_i,
    input  logic [core_pkg::XLEN-1:0] rs1_data_i,
    input  logic [core_pkg::XLEN-1:0] rs2_data_i,
    input  logic [core_pkg::XLEN-1:0] pc_i,
    input  logic [core_pkg::XLEN-1:0] imm_i,
    output logic                      br_taken_o,
    output logic [core_pkg::XLEN-1:0] br_target_o,
    output logic [core_pkg::XLEN-1:0] jalr_target_o
);
    import core_pkg::*;

    logic            br_eq;
    logic            br_lt;
    logic            br_ltu;
    logic [XLEN-1:0] jalr_sum;

    assign br_eq  = (rs1_data_i == rs2_data_i);
    assign br_lt  = ($signed(rs1_data_i) < $signed(rs2_data_i));
    assign br_ltu = (rs1_data_i < rs2_data_i);

    always_comb begin
        case (ctrl_i.br_funct3)
            3'b000:  br_taken_o = br_eq;
            3'b001:  br_taken_o = ~br_eq;
            3'b100:  br_taken_o = br_lt;
            3'b101:  br_taken_o = ~br_lt;
            3'b110:  br_taken_o = br_ltu;
            3'b111:  br_taken_o = ~br_ltu;
            default: br_taken_o = 1'b0;
        endcase
    end

    // Shared by branches and JAL
    assign br_target_o   = pc_i + imm_i;
    assign jalr_sum      = rs1_data_i + imm_i;
    assign jalr_target_o = {jalr_sum[XLEN-1:1], 1'b0};

endmodule

// File: core_checker.sv
`timescale 1ns/1ps

module core_checker (
    input logic              clk,
    input logic              rst_n_i,
    input logic              commit_valid_i,
    input core_pkg::commit_t commit_i,
    input logic              halt_i
);
    import core_pkg::*;

    localparam logic [31:0] EBREAK_WORD = 32'h0010_0073;

    int unsigned fail_count = 0;
    logic        is_ctrl;

    assign is_ctrl = commit_i.insn[6:0] inside {OPC_JAL, OPC_JALR, OPC_BRANCH};

    // Halt flag is unknown before the first reset edge
    assert property (@(posedge clk) !rst_n_i && $past(!rst_n_i) |-> !commit_valid_i && !halt_i)
    else begin
        $error("commit_valid or halt high while reset is asserted");
        fail_count++;
    end

    assert property (@(posedge clk) $rose(rst_n_i) |-> commit_valid_i && commit_i.pc == '0)
    else begin
        $error("first commit after reset is not at pc 0");
        fail_count++;
    end

    assert property (@(posedge clk) disable iff (!rst_n_i)
        commit_valid_i && !is_ctrl |-> commit_i.next_pc == commit_i.pc + 32'd4)
    else begin
        $error("next pc of a non-control instruction is not pc+4");
        fail_count++;
    end

    assert property (@(posedge clk) disable iff (!rst_n_i)
        commit_valid_i && $past(commit_valid_i) |-> commit_i.pc == $past(commit_i.next_pc))
    else begin
        $error("commit pc does not follow the previous next pc");
        fail_count++;
    end

    assert property (@(posedge clk) disable iff (!rst_n_i)
        commit_valid_i |-> !(commit_i.rd_we && commit_i.rd == '0))
    else begin
        $error("register write enabled for x0");
        fail_count++;
    end

    assert property (@(posedge clk) disable iff (!rst_n_i)
        commit_valid_i && commit_i.insn == EBREAK_WORD |=> halt_i)
    else begin
        $error("halt did not rise after EBREAK");
        fail_count++;
    end

    // Once halted nothing more retires
    assert property (@(posedge clk) disable iff (!rst_n_i) halt_i |-> !commit_valid_i ##1 halt_i)
    else begin
        $error("commit while halted or halt dropped");
        fail_count++;
    end

endmodule

// File: core_pkg.sv
package core_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // RV32I major opcodes handled by the core
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_SYSTEM = 7'b1110011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
    } alu_op_e;

    typedef enum logic [1:0] {OP1_REG, OP1_PC, OP1_ZERO} op1_sel_e;
    typedef enum logic {OP2_REG, OP2_IMM} op2_sel_e;
    typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_PC4} wb_sel_e;
    typedef enum logic [1:0] {PC_SEQ, PC_BRANCH, PC_JAL, PC_JALR} pc_sel_e;
    typedef enum logic {MEM_BYTE, MEM_WORD} mem_size_e;

    typedef struct packed {
        alu_op_e   alu_op;
        op1_sel_e  op1_sel;
        op2_sel_e  op2_sel;
        wb_sel_e   wb_sel;
        pc_sel_e   pc_sel;
        logic      rf_we;
        logic      mem_en;
        logic      mem_we;
        mem_size_e mem_size;
        logic      mem_unsigned;
        logic [2:0] br_funct3;
        logic      is_ebreak;
    } ctrl_t;

    // One retired instruction
    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic [31:0]           insn;
        logic [REG_ADDR_W-1:0] rd;
        logic                  rd_we;
        logic [XLEN-1:0]       rd_data;
        logic [XLEN-1:0]       next_pc;
    } commit_t;

endpackage

// File: core_top.sv
`timescale 1ns/1ps

module core_top #(
    parameter int IMEM_DEPTH = 256,
    parameter int DMEM_DEPTH = 256
) (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              prog_we_i,
    input  logic [7:0]        prog_addr_i,
    input  logic [31:0]       prog_wdata_i,
    output logic              commit_valid_o,
    output core_pkg::commit_t commit_o,
    output logic              halt_o
);
    import core_pkg::*;

    logic [XLEN-1:0]       pc;
    logic [31:0]           insn;
    logic [XLEN-1:0]       next_pc;
    logic                  halt;
    ctrl_t                 ctrl;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       imm;
    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;
    logic [XLEN-1:0]       alu_result;
    logic                  br_taken;
    logic [XLEN-1:0]       br_target;
    logic [XLEN-1:0]       jalr_target;
    logic [XLEN-1:0]       mem_rdata;
    logic [XLEN-1:0]       rd_data;

    fetch_unit #(.IMEM_DEPTH(IMEM_DEPTH)) u_fetch (
        .clk(clk), .rst_n_i(rst_n_i),
        .prog_we_i(prog_we_i), .prog_addr_i(prog_addr_i), .prog_wdata_i(prog_wdata_i),
        .next_pc_i(next_pc), .ebreak_i(ctrl.is_ebreak),
        .pc_o(pc), .insn_o(insn), .halt_o(halt)
    );

    decoder u_decoder (
        .insn_i(insn), .ctrl_o(ctrl), .rs1_o(rs1), .rs2_o(rs2), .rd_o(rd), .imm_o(imm)
    );

    regfile u_regfile (
        .clk(clk), .rst_n_i(rst_n_i), .we_i(ctrl.rf_we), .waddr_i(rd), .wdata_i(rd_data),
        .raddr1_i(rs1), .raddr2_i(rs2), .rdata1_o(rs1_data), .rdata2_o(rs2_data)
    );

    alu u_alu (
        .ctrl_i(ctrl), .rs1_data_i(rs1_data), .rs2_data_i(rs2_data),
        .pc_i(pc), .imm_i(imm), .result_o(alu_result)
    );

    branch_unit u_branch (
        .ctrl_i(ctrl), .rs1_data_i(rs1_data), .rs2_data_i(rs2_data), .pc_i(pc), .imm_i(imm),
        .br_taken_o(br_taken), .br_target_o(br_target), .jalr_target_o(jalr_target)
    );

    data_mem #(.DMEM_DEPTH(DMEM_DEPTH)) u_dmem (
        .clk(clk), .rst_n_i(rst_n_i), .ctrl_i(ctrl), .addr_i(alu_result),
        .wdata_i(rs2_data), .rdata_o(mem_rdata)
    );

    writeback u_writeback (
        .ctrl_i(ctrl), .alu_result_i(alu_result), .mem_rdata_i(mem_rdata), .pc_i(pc),
        .br_taken_i(br_taken), .br_target_i(br_target), .jalr_target_i(jalr_target),
        .rd_data_o(rd_data), .next_pc_o(next_pc)
    );

    // One instruction retires every cycle between reset release and halt
    assign commit_valid_o = rst_n_i & ~halt;
    assign halt_o         = halt;
    assign commit_o       = '{pc: pc, insn: insn, rd: rd, rd_we: ctrl.rf_we,
                              rd_data: rd_data, next_pc: next_pc};

endmodule

// File: data_mem.sv
`timescale 1ns/1ps

module data_mem #(
    parameter int DMEM_DEPTH = 256
) (
    input  logic                      clk,
    input  logic                      rst_n_i,
    input  core_pkg::ctrl_t           ctrl_i,
    input  logic [core_pkg::XLEN-1:0] addr_i,
    input  logic [core_pkg::XLEN-1:0] wdata_i,
    output logic [core_pkg::XLEN-1:0] rdata_o
);
    import core_pkg::*;

    localparam int IDX_W = $clog2(DMEM_DEPTH);

    logic [XLEN-1:0]  mem [DMEM_DEPTH];
    logic [IDX_W-1:0] word_idx;
    logic [XLEN-1:0]  wdata_aligned;
    logic [3:0]       wmask;

    assign word_idx = addr_i[IDX_W+1:2];

    // Byte stores put the byte on every lane and let the mask pick one
    assign wdata_aligned = (ctrl_i.mem_size == MEM_BYTE) ? {4{wdata_i[7:0]}} : wdata_i;
    assign wmask         = (ctrl_i.mem_size == MEM_BYTE) ? (4'b0001 << addr_i[1:0]) : 4'b1111;

    always_ff @(posedge clk) begin
        if (rst_n_i && ctrl_i.mem_en && ctrl_i.mem_we) begin
            for (int b = 0; b < 4; b++) begin
                if (wmask[b]) begin
                    mem[word_idx][b*8 +: 8] <= wdata_aligned[b*8 +: 8];
                end
            end
        end
    end

    assign rdata_o = mem[word_idx];

endmodule

// File: decoder.sv
`timescale 1ns/1ps

module decoder (
    input  logic [31:0]                     insn_i,
    output core_pkg::ctrl_t                 ctrl_o,
    output logic [core_pkg::REG_ADDR_W-1:0] rs1_o,
    output logic [core_pkg::REG_ADDR_W-1:0] rs2_o,
    output logic [core_pkg::REG_ADDR_W-1:0] rd_o,
    output logic [core_pkg::XLEN-1:0]       imm_o
);
    import core_pkg::*;

    localparam logic [31:0] EBREAK_INSN = 32'h0010_0073;

    opcode_e         opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [XLEN-1:0] imm_i_w;
    logic [XLEN-1:0] imm_s_w;
    logic [XLEN-1:0] imm_b_w;
    logic [XLEN-1:0] imm_u_w;
    logic [XLEN-1:0] imm_j_w;

    function automatic alu_op_e alu_from_funct3(input logic [2:0] f3, input logic alt);
        alu_op_e op;
        case (f3)
            3'b000:  op = alt ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    assign opcode = opcode_e'(insn_i[6:0]);
    assign funct3 = insn_i[14:12];
    assign funct7 = insn_i[31:25];
    assign rd_o   = insn_i[11:7];
    assign rs1_o  = insn_i[19:15];
    assign rs2_o  = insn_i[24:20];

    assign imm_i_w = {{20{insn_i[31]}}, insn_i[31:20]};
    assign imm_s_w = {{20{insn_i[31]}}, insn_i[31:25], insn_i[11:7]};
    assign imm_b_w = {{19{insn_i[31]}}, insn_i[31], insn_i[7], insn_i[30:25],
                      insn_i[11:8], 1'b0};
    assign imm_u_w = {insn_i[31:12], 12'b0};
    assign imm_j_w = {{11{insn_i[31]}}, insn_i[31], insn_i[19:12], insn_i[20],
                      insn_i[30:21], 1'b0};

    always_comb begin
        ctrl_o           = '0;
        ctrl_o.alu_op    = ALU_ADD;
        ctrl_o.op1_sel   = OP1_REG;
        ctrl_o.op2_sel   = OP2_IMM;
        ctrl_o.wb_sel    = WB_ALU;
        ctrl_o.pc_sel    = PC_SEQ;
        ctrl_o.mem_size  = MEM_WORD;
        ctrl_o.br_funct3 = funct3;
        imm_o            = imm_i_w;

        case (opcode)
            OPC_LUI: begin
                ctrl_o.op1_sel = OP1_ZERO;
                ctrl_o.alu_op  = ALU_PASS_B;
                ctrl_o.rf_we   = 1'b1;
                imm_o          = imm_u_w;
            end
            OPC_AUIPC: begin
                ctrl_o.op1_sel = OP1_PC;
                ctrl_o.rf_we   = 1'b1;
                imm_o          = imm_u_w;
            end
            OPC_JAL: begin
                ctrl_o.wb_sel = WB_PC4;
                ctrl_o.pc_sel = PC_JAL;
                ctrl_o.rf_we  = 1'b1;
                imm_o         = imm_j_w;
            end
            OPC_JALR: begin
                ctrl_o.wb_sel = WB_PC4;
                ctrl_o.pc_sel = PC_JALR;
                ctrl_o.rf_we  = 1'b1;
            end
            OPC_BRANCH: begin
                ctrl_o.pc_sel = PC_BRANCH;
                imm_o         = imm_b_w;
            end
            OPC_LOAD: begin
                // Only LB, LBU and LW are decoded
                if (funct3 == 3'b000 || funct3 == 3'b100 || funct3 == 3'b010) begin
                    ctrl_o.wb_sel       = WB_MEM;
                    ctrl_o.rf_we        = 1'b1;
                    ctrl_o.mem_en       = 1'b1;
                    ctrl_o.mem_size     = funct3[1] ? MEM_WORD : MEM_BYTE;
                    ctrl_o.mem_unsigned = funct3[2];
                end
            end
            OPC_STORE: begin
                imm_o = imm_s_w;
                if (funct3 == 3'b000 || funct3 == 3'b010) begin
                    ctrl_o.mem_en   = 1'b1;
                    ctrl_o.mem_we   = 1'b1;
                    ctrl_o.mem_size = funct3[1] ? MEM_WORD : MEM_BYTE;
                end
            end
            OPC_OP_IMM: begin
                ctrl_o.alu_op = alu_from_funct3(funct3, (funct3 == 3'b101) && funct7[5]);
                ctrl_o.rf_we  = 1'b1;
            end
            OPC_OP: begin
                ctrl_o.op2_sel = OP2_REG;
                ctrl_o.alu_op  = alu_from_funct3(funct3, funct7[5]);
                ctrl_o.rf_we   = 1'b1;
            end
            OPC_SYSTEM: begin
                ctrl_o.is_ebreak = (insn_i == EBREAK_INSN);
            end
            default: begin
            end
        endcase

        if (rd_o == '0) begin
            ctrl_o.rf_we = 1'b0;
        end
    end

endmodule

// File: fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit #(
    parameter int IMEM_DEPTH = 256
) (
    input  logic                     clk,
    input  logic                     rst_n_i,
    input  logic                     prog_we_i,
    input  logic [7:0]               prog_addr_i,
    input  logic [31:0]              prog_wdata_i,
    input  logic [core_pkg::XLEN-1:0] next_pc_i,
    input  logic                     ebreak_i,
    output logic [core_pkg::XLEN-1:0] pc_o,
    output logic [31:0]              insn_o,
    output logic                     halt_o
);
    import core_pkg::*;

    localparam int IDX_W = $clog2(IMEM_DEPTH);

    logic [31:0]     imem [IMEM_DEPTH];
    logic [XLEN-1:0] pc_q;
    logic            halt_q;

    // Program load port is only open while the core sits in reset
    always_ff @(posedge clk) begin
        if (!rst_n_i && prog_we_i) begin
            imem[prog_addr_i[IDX_W-1:0]] <= prog_wdata_i;
        end
    end

    // EBREAK keeps the PC on itself so nothing after it executes
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            pc_q   <= '0;
            halt_q <= 1'b0;
        end else if (!halt_q) begin
            if (ebreak_i) begin
                halt_q <= 1'b1;
            end else begin
                pc_q <= next_pc_i;
            end
        end
    end

    assign pc_o   = pc_q;
    assign insn_o = imem[pc_q[IDX_W+1:2]];
    assign halt_o = halt_q;

endmodule

// File: regfile.sv
`timescale 1ns/1ps

module regfile (
    input  logic                            clk,
    input  logic                            rst_n_i,
    input  logic                            we_i,
    input  logic [core_pkg::REG_ADDR_W-1:0] waddr_i,
    input  logic [core_pkg::XLEN-1:0]       wdata_i,
    input  logic [core_pkg::REG_ADDR_W-1:0] raddr1_i,
    input  logic [core_pkg::REG_ADDR_W-1:0] raddr2_i,
    output logic [core_pkg::XLEN-1:0]       rdata1_o,
    output logic [core_pkg::XLEN-1:0]       rdata2_o
);
    import core_pkg::*;

    // x0 has no storage
    logic [XLEN-1:0] regs [1:31];

    always_ff @(posedge clk) begin
        if (rst_n_i && we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

// File: tb_core.sv
`timescale 1ns/1ps

module tb_core;
    import core_pkg::*;

    localparam int N_INSN      = 40;
    localparam int SLOTS       = 64;
    localparam int CYCLE_LIMIT = 2 * N_INSN + 50;

    logic        clk;
    logic        rst_n_i;
    logic        prog_we_i;
    logic [7:0]  prog_addr_i;
    logic [31:0] prog_wdata_i;
    logic        commit_valid_o;
    commit_t     commit_o;
    logic        halt_o;

    logic [31:0] prog     [SLOTS];
    logic        chk_rd   [SLOTS];
    logic [31:0] exp_rd   [SLOTS];
    logic        chk_next [SLOTS];
    logic [31:0] exp_next [SLOTS];
    string       chk_name [SLOTS];
    int          n_words    = 0;
    int          n_checks   = 0;
    int          checks_hit = 0;
    logic [31:0] lfsr;
    logic [5:0]  pc_idx;

    core_top UUT (.*);

    bind core_top core_checker u_checker (
        .clk(clk), .rst_n_i(rst_n_i), .commit_valid_i(commit_valid_o),
        .commit_i(commit_o), .halt_i(halt_o)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    assign pc_idx = commit_o.pc[7:2];

    function automatic logic [31:0] lfsr_draw(input int nbits);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int k = 0; k < nbits; k++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            val  = {val[30:0], fb};
        end
        return val;
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
    endfunction

    // An empty name leaves the instruction unchecked
    task automatic emit(input logic [31:0] insn, input string name, input logic [31:0] rd_val);
        prog[n_words]     = insn;
        chk_rd[n_words]   = (name != "");
        exp_rd[n_words]   = rd_val;
        chk_name[n_words] = name;
        if (name != "") begin
            n_checks++;
        end
        n_words++;
    endtask

    task automatic expect_next(input logic [31:0] target);
        chk_next[n_words-1] = 1'b1;
        exp_next[n_words-1] = target;
    endtask

    assert property (@(posedge clk) disable iff (!rst_n_i)
        commit_valid_o && chk_rd[pc_idx] |-> commit_o.rd_data == exp_rd[pc_idx])
    else begin
        $display("mismatch %s: expected %h, actual %h", chk_name[$sampled(pc_idx)],
                 exp_rd[$sampled(pc_idx)], $sampled(commit_o.rd_data));
        $display("Simulation finished: FAIL");
        $fatal(1);
    end

    assert property (@(posedge clk) disable iff (!rst_n_i)
        commit_valid_o && chk_next[pc_idx] |-> commit_o.next_pc == exp_next[pc_idx])
    else begin
        $display("mismatch %s target: expected %h, actual %h", chk_name[$sampled(pc_idx)],
                 exp_next[$sampled(pc_idx)], $sampled(commit_o.next_pc));
        $display("Simulation finished: FAIL");
        $fatal(1);
    end

    // Commit record follows the loaded program word
    assert property (@(posedge clk) disable iff (!rst_n_i)
        commit_valid_o |-> commit_o.insn == prog[pc_idx])
    else begin
        $display("mismatch fetch at pc %h: expected %h, actual %h", $sampled(commit_o.pc),
                 prog[$sampled(pc_idx)], $sampled(commit_o.insn));
        $display("Simulation finished: FAIL");
        $fatal(1);
    end

    assert property (@(posedge clk) disable iff (!rst_n_i)
        commit_valid_o && chk_rd[pc_idx] |->
            commit_o.rd_we && commit_o.rd == prog[pc_idx][11:7])
    else begin
        $display("mismatch %s rd: expected x%0d written, actual x%0d with we %b",
                 chk_name[$sampled(pc_idx)], prog[$sampled(pc_idx)][11:7],
                 $sampled(commit_o.rd), $sampled(commit_o.rd_we));
        $display("Simulation finished: FAIL");
        $fatal(1);
    end

    always @(UUT.u_checker.fail_count) begin
        if (UUT.u_checker.fail_count != 0) begin
            $display("a protocol assertion in core_checker failed");
            $display("Simulation finished: FAIL");
            $fatal(1);
        end
    end

    always @(posedge clk) begin
        if (rst_n_i && commit_valid_o && chk_rd[pc_idx]) begin
            checks_hit <= checks_hit + 1;
        end
    end

    initial begin
        logic [19:0] hi1, hi2, hi3;
        logic [11:0] lo1, lo2, lo3, imm;
        logic [4:0]  sh;
        logic [31:0] a, b, w, si;
        int          cycles;
        rst_n_i      = 1'b0;
        prog_we_i    = 1'b0;
        prog_addr_i  = '0;
        prog_wdata_i = '0;
        for (int i = 0; i < SLOTS; i++) begin
            chk_rd[i]   = 1'b0;
            chk_next[i] = 1'b0;
        end

        lfsr = 32'h2d19_3f93;
        hi1  = 20'(lfsr_draw(20));
        lo1  = 12'(lfsr_draw(12));
        hi2  = 20'(lfsr_draw(20));
        lo2  = 12'(lfsr_draw(12));
        imm  = 12'(lfsr_draw(12));
        sh   = 5'(lfsr_draw(5));
        hi3  = 20'(lfsr_draw(20));
        lo3  = 12'(lfsr_draw(12));
        a    = {hi1, 12'b0} + {{20{lo1[11]}}, lo1};
        b    = {hi2, 12'b0} + {{20{lo2[11]}}, lo2};
        w    = {hi3, 12'b0} + {{20{lo3[11]}}, lo3};
        si   = {{20{imm[11]}}, imm};

        emit({hi1, 5'd1, OPC_LUI}, "lui a", {hi1, 12'b0});
        emit(enc_i(lo1, 1, 3'b000, 1, OPC_OP_IMM), "addi a", a);
        emit({hi2, 5'd2, OPC_LUI}, "lui b", {hi2, 12'b0});
        emit(enc_i(lo2, 2, 3'b000, 2, OPC_OP_IMM), "addi b", b);
        emit(enc_r(7'h00, 2, 1, 3'b000, 3), "add", a + b);
        emit(enc_r(7'h20, 2, 1, 3'b000, 4), "sub", a - b);
        emit(enc_r(7'h00, 2, 1, 3'b010, 5), "slt", {31'b0, $signed(a) < $signed(b)});
        emit(enc_r(7'h00, 2, 1, 3'b011, 6), "sltu", {31'b0, a < b});
        emit(enc_r(7'h00, 2, 1, 3'b100, 7), "xor", a ^ b);
        emit(enc_r(7'h20, 2, 1, 3'b101, 8), "sra", $unsigned($signed(a) >>> b[4:0]));
        emit(enc_r(7'h00, 2, 1, 3'b110, 9), "or", a | b);
        emit(enc_i(imm, 1, 3'b000, 10, OPC_OP_IMM), "addi", a + si);
        emit(enc_i(imm, 1, 3'b010, 11, OPC_OP_IMM), "slti", {31'b0, $signed(a) < $signed(si)});
        emit(enc_i(imm, 1, 3'b011, 12, OPC_OP_IMM), "sltiu", {31'b0, a < si});
        emit(enc_i(imm, 1, 3'b100, 13, OPC_OP_IMM), "xori", a ^ si);
        emit(enc_i({7'h20, sh}, 1, 3'b101, 14, OPC_OP_IMM), "srai", $unsigned($signed(a) >>> sh));
        emit(enc_i(imm, 1, 3'b110, 15, OPC_OP_IMM), "ori", a | si);

        // Sum 1..10 with a BNE back to word 20
        emit(enc_i(12'd0, 0, 3'b000, 16, OPC_OP_IMM), "sum init", 32'd0);
        emit(enc_i(12'd1, 0, 3'b000, 17, OPC_OP_IMM), "count init", 32'd1);
        emit(enc_i(12'd11, 0, 3'b000, 18, OPC_OP_IMM), "limit", 32'd11);
        emit(enc_r(7'h00, 17, 16, 3'b000, 16), "", '0);
        emit(enc_i(12'd1, 17, 3'b000, 17, OPC_OP_IMM), "", '0);
        emit(enc_b(13'h1FF8, 18, 17, 3'b001), "", '0);
        emit(enc_i(12'd0, 16, 3'b000, 19, OPC_OP_IMM), "sum 1 to 10", 32'd55);

        // JAL at 96 skips word 25, JALR at 108 clears bit 0 of 117
        emit(enc_j(21'd8, 20), "jal link", 32'd100);
        expect_next(32'd104);
        emit(enc_i(12'd1, 0, 3'b000, 21, OPC_OP_IMM), "", '0);
        emit(enc_i(12'd117, 0, 3'b000, 22, OPC_OP_IMM), "jalr base", 32'd117);
        emit(enc_i(12'd0, 22, 3'b000, 23, OPC_JALR), "jalr link", 32'd112);
        expect_next(32'd116);
        emit(enc_i(12'd2, 0, 3'b000, 21, OPC_OP_IMM), "", '0);

        emit({hi3, 5'd24, OPC_LUI}, "lui w", {hi3, 12'b0});
        emit(enc_i(lo3, 24, 3'b000, 24, OPC_OP_IMM), "addi w", w);
        emit(enc_i(12'hFF1, 0, 3'b000, 25, OPC_OP_IMM), "byte value", 32'hFFFF_FFF1);
        emit(enc_s(12'd64, 24, 0, 3'b010), "", '0);
        emit(enc_s(12'd65, 25, 0, 3'b000), "", '0);
        emit(enc_i(12'd64, 0, 3'b010, 26, OPC_LOAD), "lw merged", {w[31:16], 8'hF1, w[7:0]});
        emit(enc_i(12'd65, 0, 3'b000, 27, OPC_LOAD), "lb", 32'hFFFF_FFF1);
        emit(enc_i(12'd65, 0, 3'b100, 28, OPC_LOAD), "lbu", 32'h0000_00F1);

        // A write aimed at x0 must not enable the register write
        emit(enc_r(7'h00, 2, 1, 3'b000, 0), "", '0);
        emit(enc_i(12'd0, 0, 3'b000, 29, OPC_OP_IMM), "x0 reads zero", 32'd0);
        emit(32'h0010_0073, "", '0);

        for (int i = 0; i < n_words; i++) begin
            @(posedge clk);
            prog_we_i    <= 1'b1;
            prog_addr_i  <= 8'(i);
            prog_wdata_i <= prog[i];
        end
        @(posedge clk);
        prog_we_i <= 1'b0;
        repeat (5) @(posedge clk);
        rst_n_i <= 1'b1;

        cycles = 0;
        while (!halt_o && cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        repeat (3) @(posedge clk);

        if (halt_o && checks_hit == n_checks) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            if (!halt_o) begin
                $display("timeout: core did not halt within %0d cycles", CYCLE_LIMIT);
            end else begin
                $display("only %0d of %0d checked instructions committed", checks_hit, n_checks);
            end
            $display("Simulation finished: FAIL");
            $fatal(1);
        end
    end

endmodule

// File: vlog.f
core_pkg.sv
fetch_unit.sv
decoder.sv
regfile.sv
alu.sv
branch_unit.sv
data_mem.sv
writeback.sv
core_top.sv
core_checker.sv
tb_core.sv

// File: writeback.sv
`timescale 1ns/1ps

module writeback (
    input  core_pkg::ctrl_t           ctrl_i,
    input  logic [core_pkg::XLEN-1:0] alu_result_i,
    input  logic [core_pkg::XLEN-1:0] mem_rdata_i,
    input  logic [core_pkg::XLEN-1:0] pc_i,
    input  logic                      br_taken_i,
    input  logic [core_pkg::XLEN-1:0] br_target_i,
    input  logic [core_pkg::XLEN-1:0] jalr_target_i,
    output logic [core_pkg::XLEN-1:0] rd_data_o,
    output logic [core_pkg::XLEN-1:0] next_pc_o
);
    import core_pkg::*;

    logic [XLEN-1:0] pc_plus4;
    logic [XLEN-1:0] lane_shifted;
    logic [7:0]      load_byte;
    logic [XLEN-1:0] load_data;

    assign pc_plus4     = pc_i + 32'd4;
    assign lane_shifted = mem_rdata_i >> {alu_result_i[1:0], 3'b000};
    assign load_byte    = lane_shifted[7:0];

    always_comb begin
        if (ctrl_i.mem_size == MEM_WORD) begin
            load_data = mem_rdata_i;
        end else if (ctrl_i.mem_unsigned) begin
            load_data = {24'b0, load_byte};
        end else begin
            load_data = {{24{load_byte[7]}}, load_byte};
        end

        case (ctrl_i.wb_sel)
            WB_MEM:  rd_data_o = load_data;
            WB_PC4:  rd_data_o = pc_plus4;
            default: rd_data_o = alu_result_i;
        endcase

        case (ctrl_i.pc_sel)
            PC_BRANCH: next_pc_o = br_taken_i ? br_target_i : pc_plus4;
            PC_JAL:    next_pc_o = br_target_i;
            PC_JALR:   next_pc_o = jalr_target_i;
            default:   next_pc_o = pc_plus4;
        endcase
    end

endmodule
